// File: common/eth_mgmt_pkg.sv
// --------------------
// Shared widths, register map, interrupt bit positions and
// MDIO constants for the Ethernet management block.
// Modules take these with a wildcard import in their header.
// --------------------
`default_nettype none

package eth_mgmt_pkg;

    // Host bus
    localparam int AXIL_ADDR_BITS = 16;
    localparam int AXIL_DATA_BITS = 32;
    localparam int CSR_ADDR_BITS = 12;

    typedef logic [AXIL_DATA_BITS-1:0] csr_data_t;

    // Register map, low 12 address bits
    typedef enum logic [CSR_ADDR_BITS-1:0] {
        CSR_STATUS      = 12'h000,
        CSR_INT_ENABLE  = 12'h008,
        CSR_INT_STATUS  = 12'h00C,
        CSR_CONTROL     = 12'h020,
        CSR_MDIO_FRAME  = 12'h024,
        CSR_MDIO_RESULT = 12'h028,
        CSR_CONFIG      = 12'h02C
    } csr_addr_e;

    // Bit 8 flags MDIO present
    localparam csr_data_t CONFIG_VALUE = 32'h0000_0100;

    localparam int INT_MDIO_IDLE_BIT = 18;
    localparam int INT_PHY_BIT = 19;
    localparam int CTRL_PHY_RESET_BIT = 2;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // MDC half period is reload + 1 clocks
    localparam int MDIO_DIV_RELOAD = 24;
    localparam int MDIO_PREAMBLE_BITS = 32;
    localparam int MDIO_FRAME_BITS = 32;
    localparam int MDIO_READ_OP_BIT = 29;
    localparam int MDIO_RELEASE_BIT = 17;

    typedef enum logic [2:0] {
        MDIO_IDLE,
        MDIO_PREAMBLE,
        MDIO_SHIFT,
        MDIO_STOP,
        MDIO_DONE
    } mdio_state_e;

endpackage

`default_nettype wire

// File: verilog/host_if/axil_slave.sv
// --------------------
// AXI-lite register slave. Captures read address, write
// address and write data independently, issues one-cycle
// access pulses to the register bank and returns OKAY
// responses. Read data is registered on the access pulse.
// --------------------
`default_nettype none

module axil_slave
    import eth_mgmt_pkg::*;
(
    input  wire                       clock,
    input  wire                       reset,

    input  wire [AXIL_ADDR_BITS-1:0]  s_axi_awaddr_i,
    input  wire                       s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  wire [AXIL_DATA_BITS-1:0]  s_axi_wdata_i,
    input  wire                       s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  wire                       s_axi_bready_i,
    input  wire [AXIL_ADDR_BITS-1:0]  s_axi_araddr_i,
    input  wire                       s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output csr_data_t                 s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  wire                       s_axi_rready_i,

    output logic                      wr_en_o,
    output logic [CSR_ADDR_BITS-1:0]  wr_addr_o,
    output csr_data_t                 wr_data_o,
    output logic                      rd_en_o,
    output logic [CSR_ADDR_BITS-1:0]  rd_addr_o,
    input  csr_data_t                 rd_data_i
);

    logic rd_pending;
    logic aw_held;
    logic w_held;

    // Ready stays low from capture until the response is taken
    assign s_axi_arready_o = !rd_pending && !s_axi_rvalid_o;
    assign s_axi_awready_o = !aw_held && !s_axi_bvalid_o;
    assign s_axi_wready_o = !w_held && !s_axi_bvalid_o;

    assign s_axi_rresp_o = AXI_RESP_OKAY;
    assign s_axi_bresp_o = AXI_RESP_OKAY;

    assign rd_en_o = rd_pending && !s_axi_rvalid_o;
    assign wr_en_o = aw_held && w_held && !s_axi_bvalid_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_pending <= 1'b0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
            s_axi_bvalid_o <= 1'b0;
        end else begin
            if (s_axi_arvalid_i && s_axi_arready_o) begin
                rd_pending <= 1'b1;
            end
            if (s_axi_rvalid_o && s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end else if (rd_en_o) begin
                s_axi_rvalid_o <= 1'b1;
                rd_pending <= 1'b0;
            end

            if (s_axi_awvalid_i && s_axi_awready_o) begin
                aw_held <= 1'b1;
            end
            if (s_axi_wvalid_i && s_axi_wready_o) begin
                w_held <= 1'b1;
            end
            // Address and data both held, in either order
            if (s_axi_bvalid_o && s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end else if (wr_en_o) begin
                s_axi_bvalid_o <= 1'b1;
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (s_axi_arvalid_i && s_axi_arready_o) begin
            rd_addr_o <= s_axi_araddr_i[CSR_ADDR_BITS-1:0];
        end
        if (s_axi_awvalid_i && s_axi_awready_o) begin
            wr_addr_o <= s_axi_awaddr_i[CSR_ADDR_BITS-1:0];
        end
        if (s_axi_wvalid_i && s_axi_wready_o) begin
            wr_data_o <= s_axi_wdata_i;
        end
        if (rd_en_o) begin
            s_axi_rdata_o <= rd_data_i;
        end
    end

    // Read response held under back-pressure
    rvalid_stable: assert property (@(posedge clock) disable iff (reset)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
        else $error("rvalid or rdata changed while rready low");

    bvalid_stable: assert property (@(posedge clock) disable iff (reset)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
        else $error("bvalid dropped while bready low");

endmodule

`default_nettype wire

// File: verilog/host_if/csr_regs.sv
// --------------------
// General register bank. Decodes single-cycle write and read
// pulses from the host slave, holds interrupt enable, control
// and the MDIO frame, builds interrupt status and drives the
// level interrupt and the PHY reset.
// --------------------
`default_nettype none

module csr_regs
    import eth_mgmt_pkg::*;
(
    input  wire                       clock,
    input  wire                       reset,

    input  wire                       wr_en_i,
    input  wire [CSR_ADDR_BITS-1:0]   wr_addr_i,
    input  csr_data_t                 wr_data_i,
    input  wire                       rd_en_i,
    input  wire [CSR_ADDR_BITS-1:0]   rd_addr_i,
    output csr_data_t                 rd_data_o,

    input  wire [15:0]                status_vector_i,
    input  wire                       mdio_int_i,
    output logic                      interrupt_o,
    output logic                      phy_reset_n_o,

    output logic                      mdio_start_o,
    output csr_data_t                 mdio_frame_o,
    input  wire                       mdio_done_i,
    input  csr_data_t                 mdio_rx_data_i
);

    csr_addr_e  wr_sel;
    csr_addr_e  rd_sel;
    csr_data_t  int_enable;
    csr_data_t  int_status;
    logic       phy_reset;
    logic [2:0] phy_int_sync;
    logic       mdio_idle;
    logic       frame_wr;

    assign wr_sel = csr_addr_e'(wr_addr_i);
    assign rd_sel = csr_addr_e'(rd_addr_i);

    // Idle once the start/done exchange has fully unwound
    assign mdio_idle = !(mdio_start_o || mdio_done_i);

    // Frame writes while a frame is in flight are dropped
    assign frame_wr = wr_en_i && (wr_sel == CSR_MDIO_FRAME) && mdio_idle;

    always_comb begin
        int_status = '0;
        int_status[15:0] = status_vector_i;
        int_status[INT_MDIO_IDLE_BIT] = mdio_idle;
        int_status[INT_PHY_BIT] = phy_int_sync[2];
    end

    assign interrupt_o = |(int_enable & int_status);
    assign phy_reset_n_o = !phy_reset;

    always_comb begin
        rd_data_o = '0;
        if (rd_en_i) begin
            case (rd_sel)
                CSR_STATUS:      rd_data_o[15:0] = status_vector_i;
                CSR_INT_ENABLE:  rd_data_o = int_enable;
                CSR_INT_STATUS:  rd_data_o = int_status;
                CSR_CONTROL:     rd_data_o[CTRL_PHY_RESET_BIT] = phy_reset;
                CSR_MDIO_FRAME:  rd_data_o = mdio_frame_o;
                CSR_MDIO_RESULT: rd_data_o = mdio_rx_data_i;
                CSR_CONFIG:      rd_data_o = CONFIG_VALUE;
                default:         rd_data_o = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            int_enable <= '0;
            phy_reset <= 1'b0;
            mdio_start_o <= 1'b0;
        end else begin
            if (wr_en_i && wr_sel == CSR_INT_ENABLE) begin
                int_enable <= wr_data_i;
            end
            if (wr_en_i && wr_sel == CSR_CONTROL) begin
                phy_reset <= wr_data_i[CTRL_PHY_RESET_BIT];
            end
            // Start is a level, dropped once the master reports done
            if (frame_wr) begin
                mdio_start_o <= 1'b1;
            end else if (mdio_start_o && mdio_done_i) begin
                mdio_start_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (frame_wr) begin
            mdio_frame_o <= wr_data_i;
        end
    end

    // PHY interrupt pin is asynchronous
    always_ff @(posedge clock) begin
        if (reset) begin
            phy_int_sync <= '0;
        end else begin
            phy_int_sync <= {phy_int_sync[1:0], mdio_int_i};
        end
    end

    // Master releases done one clock after start drops
    done_after_start: assert property (@(posedge clock) disable iff (reset)
        !mdio_start_o && mdio_done_i |=> !mdio_done_i)
        else $error("MDIO done still high after start dropped");

endmodule

`default_nettype wire

// File: verilog/mdio/mdio_master.sv
// --------------------
// MDIO management master. On a start level it sends a
// 32-bit preamble of ones and then the 32-bit frame MSB
// first, one bit per MDC period, releasing the line for the
// read part of read frames. Every frame bit is sampled back
// on the MDC rising edge. Done holds until start drops.
// --------------------
`default_nettype none

module mdio_master
    import eth_mgmt_pkg::*;
(
    input  wire        clock,
    input  wire        reset,

    input  wire        start_i,
    input  csr_data_t  frame_i,
    output logic       done_o,
    output csr_data_t  rx_data_o,

    output logic       mdc_o,
    output logic       mdio_o,
    output logic       mdio_oe_o,
    input  wire        mdio_i
);

    mdio_state_e state;
    logic [4:0]  div_cnt;
    logic [4:0]  bit_cnt;
    logic [4:0]  bit_pos;
    logic        tick;
    logic        read_frame;
    logic        sample_en;

    assign tick = (div_cnt == '0);
    assign bit_pos = ~bit_cnt;
    assign read_frame = frame_i[MDIO_READ_OP_BIT];

    // Rising MDC edge inside the frame
    assign sample_en = start_i && (state == MDIO_SHIFT) && tick && !mdc_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= MDIO_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            mdc_o <= 1'b0;
            mdio_o <= 1'b1;
            mdio_oe_o <= 1'b0;
            done_o <= 1'b0;
        end else if (state == MDIO_IDLE) begin
            if (start_i) begin
                // First preamble bit goes out right away
                state <= MDIO_PREAMBLE;
                div_cnt <= 5'(MDIO_DIV_RELOAD);
                bit_cnt <= '0;
                mdio_o <= 1'b1;
                mdio_oe_o <= 1'b1;
            end
        end else if (!start_i) begin
            state <= MDIO_IDLE;
            mdc_o <= 1'b0;
            mdio_o <= 1'b1;
            mdio_oe_o <= 1'b0;
            done_o <= 1'b0;
        end else if (state == MDIO_DONE) begin
            // Wait for start to drop
        end else if (!tick) begin
            div_cnt <= div_cnt - 1'b1;
        end else begin
            div_cnt <= 5'(MDIO_DIV_RELOAD);
            if (!mdc_o) begin
                mdc_o <= 1'b1;
                if (int'(bit_cnt) == MDIO_FRAME_BITS - 1) begin
                    bit_cnt <= '0;
                    state <= (state == MDIO_PREAMBLE) ? MDIO_SHIFT : MDIO_STOP;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                mdc_o <= 1'b0;
                case (state)
                    MDIO_PREAMBLE: begin
                        mdio_o <= 1'b1;
                        mdio_oe_o <= 1'b1;
                    end
                    MDIO_SHIFT: begin
                        mdio_o <= frame_i[bit_pos];
                        // PHY owns the line from turnaround on
                        mdio_oe_o <= !(read_frame && int'(bit_pos) <= MDIO_RELEASE_BIT);
                    end
                    MDIO_STOP: begin
                        mdio_o <= 1'b1;
                        mdio_oe_o <= 1'b1;
                        done_o <= 1'b1;
                        state <= MDIO_DONE;
                    end
                    default: begin
                        state <= MDIO_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sample_en) begin
            rx_data_o[bit_pos] <= mdio_i;
        end
    end

    mdc_low_in_idle: assert property (@(posedge clock) disable iff (reset)
        state == MDIO_IDLE |-> !mdc_o)
        else $error("MDC high while MDIO idle");

endmodule

`default_nettype wire

// File: verilog/eth_mgmt_top.sv
// --------------------
// Ethernet management top level. Connects the AXI-lite
// slave to the register bank and the register bank to the
// MDIO master. The MDIO line is split into out, enable and in.
// --------------------
`default_nettype none

module eth_mgmt_top
    import eth_mgmt_pkg::*;
(
    input  wire                       clock,
    input  wire                       reset,

    input  wire [AXIL_ADDR_BITS-1:0]  s_axi_awaddr_i,
    input  wire                       s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  wire [AXIL_DATA_BITS-1:0]  s_axi_wdata_i,
    input  wire                       s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  wire                       s_axi_bready_i,
    input  wire [AXIL_ADDR_BITS-1:0]  s_axi_araddr_i,
    input  wire                       s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output csr_data_t                 s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  wire                       s_axi_rready_i,

    input  wire [15:0]                status_vector_i,
    input  wire                       mdio_int_i,
    output logic                      interrupt_o,
    output logic                      phy_reset_n_o,

    output logic                      mdc_o,
    output logic                      mdio_o,
    output logic                      mdio_oe_o,
    input  wire                       mdio_i
);

    logic                     wr_en;
    logic [CSR_ADDR_BITS-1:0] wr_addr;
    csr_data_t                wr_data;
    logic                     rd_en;
    logic [CSR_ADDR_BITS-1:0] rd_addr;
    csr_data_t                rd_data;
    logic                     mdio_start;
    csr_data_t                mdio_frame;
    logic                     mdio_done;
    csr_data_t                mdio_rx_data;

    axil_slave axil_slave_inst (
        .clock(clock),
        .reset(reset),
        .s_axi_awaddr_i(s_axi_awaddr_i),
        .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_wdata_i(s_axi_wdata_i),
        .s_axi_wvalid_i(s_axi_wvalid_i),
        .s_axi_wready_o(s_axi_wready_o),
        .s_axi_bresp_o(s_axi_bresp_o),
        .s_axi_bvalid_o(s_axi_bvalid_o),
        .s_axi_bready_i(s_axi_bready_i),
        .s_axi_araddr_i(s_axi_araddr_i),
        .s_axi_arvalid_i(s_axi_arvalid_i),
        .s_axi_arready_o(s_axi_arready_o),
        .s_axi_rdata_o(s_axi_rdata_o),
        .s_axi_rresp_o(s_axi_rresp_o),
        .s_axi_rvalid_o(s_axi_rvalid_o),
        .s_axi_rready_i(s_axi_rready_i),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .wr_data_o(wr_data),
        .rd_en_o(rd_en),
        .rd_addr_o(rd_addr),
        .rd_data_i(rd_data)
    );

    csr_regs csr_regs_inst (
        .clock(clock),
        .reset(reset),
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .rd_en_i(rd_en),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data),
        .status_vector_i(status_vector_i),
        .mdio_int_i(mdio_int_i),
        .interrupt_o(interrupt_o),
        .phy_reset_n_o(phy_reset_n_o),
        .mdio_start_o(mdio_start),
        .mdio_frame_o(mdio_frame),
        .mdio_done_i(mdio_done),
        .mdio_rx_data_i(mdio_rx_data)
    );

    mdio_master mdio_master_inst (
        .clock(clock),
        .reset(reset),
        .start_i(mdio_start),
        .frame_i(mdio_frame),
        .done_o(mdio_done),
        .rx_data_o(mdio_rx_data),
        .mdc_o(mdc_o),
        .mdio_o(mdio_o),
        .mdio_oe_o(mdio_oe_o),
        .mdio_i(mdio_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// --------------------
// Free-running clock for the testbench, period of 40
// time units, starting low.
// --------------------
`default_nettype none

module tb_clock_gen (
    output logic clock_o
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clock_o = 1'b0;
        forever begin
            #HALF_PERIOD clock_o = ~clock_o;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_eth_mgmt.sv
// --------------------
// Directed testbench for the Ethernet management block.
// Drives the AXI-lite slave, models the PHY side of the
// MDIO line and checks registers, interrupts and frames.
// Stops at the first mismatch or at the cycle limit.
// --------------------
`default_nettype none

module tb_eth_mgmt
    import eth_mgmt_pkg::*;
();

    localparam int DRIVE_DELAY = 5;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int ORDER_BOTH = 0;
    localparam int ORDER_AW_FIRST = 1;
    localparam int ORDER_W_FIRST = 2;
    localparam logic [31:0] RANDOM_SEED = 32'hff95_6116;
    localparam logic [31:0] EXPECTED_CONFIG = 32'h0000_0100;

    logic        clock;
    logic        reset;
    logic [15:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [15:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [15:0] status_vector;
    logic        mdio_int;
    logic        interrupt;
    logic        phy_reset_n;
    logic        mdc;
    logic        mdio_out;
    logic        mdio_oe;
    logic        mdio_in;

    // PHY line model state
    logic [15:0] phy_word;
    logic        phy_line;
    int          phy_pos;
    int          rise_count = 0;
    logic        mdc_prev = 1'b0;
    logic        line_q[$];
    logic        oe_q[$];
    int          cycle_count = 0;
    int          error_count = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clock_o(clock)
    );

    eth_mgmt_top eth_mgmt_top_inst (
        .clock(clock),
        .reset(reset),
        .s_axi_awaddr_i(s_axi_awaddr),
        .s_axi_awvalid_i(s_axi_awvalid),
        .s_axi_awready_o(s_axi_awready),
        .s_axi_wdata_i(s_axi_wdata),
        .s_axi_wvalid_i(s_axi_wvalid),
        .s_axi_wready_o(s_axi_wready),
        .s_axi_bresp_o(s_axi_bresp),
        .s_axi_bvalid_o(s_axi_bvalid),
        .s_axi_bready_i(s_axi_bready),
        .s_axi_araddr_i(s_axi_araddr),
        .s_axi_arvalid_i(s_axi_arvalid),
        .s_axi_arready_o(s_axi_arready),
        .s_axi_rdata_o(s_axi_rdata),
        .s_axi_rresp_o(s_axi_rresp),
        .s_axi_rvalid_o(s_axi_rvalid),
        .s_axi_rready_i(s_axi_rready),
        .status_vector_i(status_vector),
        .mdio_int_i(mdio_int),
        .interrupt_o(interrupt),
        .phy_reset_n_o(phy_reset_n),
        .mdc_o(mdc),
        .mdio_o(mdio_out),
        .mdio_oe_o(mdio_oe),
        .mdio_i(mdio_in)
    );

    // Frame bit about to be sampled, from the count of MDC rises
    always_comb begin
        phy_pos = 63 - rise_count;
        if (phy_pos > 16 || phy_pos < 0) begin
            phy_line = 1'b1;
        end else if (phy_pos == 16) begin
            phy_line = 1'b0;
        end else begin
            phy_line = phy_word[phy_pos[3:0]];
        end
    end

    assign mdio_in = mdio_oe ? mdio_out : phy_line;

    // Line and enable at every MDC rise, sampled away from the clock edge
    always @(negedge clock) begin
        if (mdc && !mdc_prev) begin
            line_q.push_back(mdio_out);
            oe_q.push_back(mdio_oe);
            rise_count = rise_count + 1;
        end
        mdc_prev = mdc;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] expected_int_status(input logic [15:0] sv,
                                                        input logic idle, input logic phy);
        logic [31:0] word;
        word = {16'h0000, sv};
        word[INT_MDIO_IDLE_BIT] = idle;
        word[INT_PHY_BIT] = phy;
        return word;
    endfunction

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input int order);
        logic aw_hs;
        logic w_hs;
        logic aw_left;
        logic w_left;
        aw_left = 1'b1;
        w_left = 1'b1;
        if (order != ORDER_W_FIRST) begin
            s_axi_awaddr = addr;
            s_axi_awvalid = 1'b1;
        end
        if (order != ORDER_AW_FIRST) begin
            s_axi_wdata = data;
            s_axi_wvalid = 1'b1;
        end
        while (aw_left || w_left) begin
            aw_hs = s_axi_awvalid && s_axi_awready;
            w_hs = s_axi_wvalid && s_axi_wready;
            next_cycle();
            if (aw_hs) begin
                s_axi_awvalid = 1'b0;
                aw_left = 1'b0;
                if (w_left && !s_axi_wvalid) begin
                    s_axi_wdata = data;
                    s_axi_wvalid = 1'b1;
                end
            end
            if (w_hs) begin
                s_axi_wvalid = 1'b0;
                w_left = 1'b0;
                if (aw_left && !s_axi_awvalid) begin
                    s_axi_awaddr = addr;
                    s_axi_awvalid = 1'b1;
                end
            end
        end
        // Response one edge after the later beat
        check_equal(32'(s_axi_bvalid), 32'd0, "bvalid before response edge");
        next_cycle();
        check_equal(32'(s_axi_bvalid), 32'd1, "bvalid after both beats");
        check_equal(32'(s_axi_bresp), 32'd0, "bresp");
        s_axi_bready = 1'b1;
        next_cycle();
        s_axi_bready = 1'b0;
        check_equal(32'(s_axi_bvalid), 32'd0, "bvalid after bready");
    endtask

    task automatic axil_read(input logic [15:0] addr, input int hold_cycles,
                             output logic [31:0] data);
        logic [31:0] held;
        check_equal(32'(s_axi_arready), 32'd1, "arready before read");
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        next_cycle();
        s_axi_arvalid = 1'b0;
        check_equal(32'(s_axi_rvalid), 32'd0, "rvalid at AR edge");
        next_cycle();
        check_equal(32'(s_axi_rvalid), 32'd1, "rvalid one edge after AR");
        check_equal(32'(s_axi_rresp), 32'd0, "rresp");
        held = s_axi_rdata;
        repeat (hold_cycles) begin
            // A second request must wait while the response is held
            s_axi_arvalid = 1'b1;
            next_cycle();
            check_equal(32'(s_axi_rvalid), 32'd1, "rvalid under back-pressure");
            check_equal(s_axi_rdata, held, "rdata under back-pressure");
            check_equal(32'(s_axi_arready), 32'd0, "arready under back-pressure");
        end
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b1;
        next_cycle();
        s_axi_rready = 1'b0;
        check_equal(32'(s_axi_rvalid), 32'd0, "rvalid after rready");
        data = held;
    endtask

    task automatic mdio_wait_idle();
        logic [31:0] status;
        status = '0;
        while (!status[INT_MDIO_IDLE_BIT]) begin
            axil_read(16'(CSR_INT_STATUS), 0, status);
        end
    endtask

    task automatic check_reset_values();
        logic [31:0] data;
        check_equal(32'(interrupt), 32'd0, "interrupt after reset");
        check_equal(32'(mdc), 32'd0, "mdc after reset");
        check_equal(32'(mdio_oe), 32'd0, "mdio_oe after reset");
        check_equal(32'(phy_reset_n), 32'd1, "phy_reset_n after reset");
        check_equal(32'(s_axi_bvalid), 32'd0, "bvalid after reset");
        check_equal(32'(s_axi_awready), 32'd1, "awready after reset");
        check_equal(32'(s_axi_wready), 32'd1, "wready after reset");
        axil_read(16'(CSR_STATUS), 0, data);
        check_equal(data, {16'h0000, status_vector}, "status register");
        axil_read(16'(CSR_CONFIG), 0, data);
        check_equal(data, EXPECTED_CONFIG, "config register");
        axil_read(16'(CSR_INT_ENABLE), 0, data);
        check_equal(data, 32'd0, "interrupt enable after reset");
        axil_read(16'(CSR_CONTROL), 0, data);
        check_equal(data, 32'd0, "control after reset");
        axil_read(16'h0800, 0, data);
        check_equal(data, 32'd0, "descriptor window read");
    endtask

    task automatic register_rw();
        logic [31:0] wr_value;
        logic [31:0] data;
        for (int order = ORDER_BOTH; order <= ORDER_W_FIRST; order++) begin
            wr_value = $urandom();
            axil_write(16'(CSR_INT_ENABLE), wr_value, order);
            axil_read(16'(CSR_INT_ENABLE), 0, data);
            check_equal(data, wr_value, $sformatf("int enable readback, order %0d", order));
        end
        axil_write(16'(CSR_CONTROL), 32'h0000_0004, ORDER_BOTH);
        check_equal(32'(phy_reset_n), 32'd0, "phy_reset_n with reset bit set");
        axil_read(16'(CSR_CONTROL), 0, data);
        check_equal(data, 32'h0000_0004, "control readback");
        axil_write(16'(CSR_CONTROL), 32'd0, ORDER_BOTH);
        check_equal(32'(phy_reset_n), 32'd1, "phy_reset_n with reset bit clear");
        axil_write(16'(CSR_INT_ENABLE), 32'd0, ORDER_BOTH);
    endtask

    task automatic interrupt_rules();
        logic [15:0] sv;
        logic [31:0] enable;
        logic [31:0] expected;
        logic [31:0] data;
        repeat (4) begin
            sv = 16'($urandom());
            enable = $urandom();
            status_vector = sv;
            axil_write(16'(CSR_INT_ENABLE), enable, ORDER_BOTH);
            expected = expected_int_status(sv, 1'b1, 1'b0);
            axil_read(16'(CSR_INT_STATUS), 0, data);
            check_equal(data, expected, "interrupt status");
            check_equal(32'(interrupt), 32'(|(enable & expected)), "interrupt rule");
        end
        sv = 16'($urandom()) | 16'h0001;
        status_vector = sv;
        axil_write(16'(CSR_INT_ENABLE), {16'h0000, sv}, ORDER_BOTH);
        check_equal(32'(interrupt), 32'd1, "interrupt on status vector");
        status_vector = 16'h0000;
        axil_write(16'(CSR_INT_ENABLE), 32'd1 << INT_MDIO_IDLE_BIT, ORDER_BOTH);
        check_equal(32'(interrupt), 32'd1, "interrupt on MDIO idle");
        axil_write(16'(CSR_INT_ENABLE), 32'd1 << INT_PHY_BIT, ORDER_BOTH);
        check_equal(32'(interrupt), 32'd0, "PHY interrupt before pin");
        // Three flop synchronizer
        mdio_int = 1'b1;
        next_cycle();
        next_cycle();
        check_equal(32'(interrupt), 32'd0, "PHY interrupt after two clocks");
        next_cycle();
        check_equal(32'(interrupt), 32'd1, "PHY interrupt after three clocks");
        axil_read(16'(CSR_INT_STATUS), 0, data);
        check_equal(data, expected_int_status(16'h0000, 1'b1, 1'b1), "status with PHY bit");
        mdio_int = 1'b0;
        repeat (3) next_cycle();
        axil_write(16'(CSR_INT_ENABLE), 32'd0, ORDER_BOTH);
    endtask

    task automatic mdio_frame_run(input logic [31:0] frame, input logic is_read);
        logic [31:0] shift_word;
        logic [31:0] data;
        logic [31:0] expected;
        int pos;
        line_q.delete();
        oe_q.delete();
        rise_count = 0;
        phy_word = 16'($urandom());
        axil_write(16'(CSR_MDIO_FRAME), frame, ORDER_BOTH);
        mdio_wait_idle();
        check_equal(32'(line_q.size()), 32'd64, "MDC rising edges per frame");
        for (int i = 0; i < 32; i++) begin
            check_equal(32'(line_q[i]), 32'd1, $sformatf("preamble bit %0d", i));
            check_equal(32'(oe_q[i]), 32'd1, $sformatf("preamble oe %0d", i));
        end
        shift_word = frame;
        for (int i = 32; i < 64; i++) begin
            pos = 63 - i;
            if (!is_read || pos > 17) begin
                check_equal(32'(line_q[i]), 32'(shift_word[31]), $sformatf("frame bit %0d", pos));
                check_equal(32'(oe_q[i]), 32'd1, $sformatf("oe at frame bit %0d", pos));
            end else begin
                check_equal(32'(oe_q[i]), 32'd0, $sformatf("released at frame bit %0d", pos));
            end
            shift_word = shift_word << 1;
        end
        check_equal(32'(mdio_oe), 32'd0, "mdio_oe after frame");
        if (is_read) begin
            expected = {frame[31:18], 1'b1, 1'b0, phy_word};
        end else begin
            expected = frame;
        end
        axil_read(16'(CSR_MDIO_RESULT), 0, data);
        check_equal(data, expected, "MDIO result");
    endtask

    task automatic read_backpressure();
        logic [31:0] wr_value;
        logic [31:0] data;
        wr_value = $urandom();
        axil_write(16'(CSR_INT_ENABLE), wr_value, ORDER_BOTH);
        axil_read(16'(CSR_INT_ENABLE), 5, data);
        check_equal(data, wr_value, "read under back-pressure");
        axil_write(16'(CSR_INT_ENABLE), 32'd0, ORDER_BOTH);
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        reset = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        status_vector = 16'($urandom());
        mdio_int = 1'b0;
        phy_word = '0;
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_reset_values();
        register_rw();
        interrupt_rules();
        // Write frame has op bits 01, read frame 10
        mdio_frame_run({4'b0101, 28'($urandom())}, 1'b0);
        mdio_frame_run({4'b0110, 28'($urandom())}, 1'b1);
        read_backpressure();

        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/eth_mgmt_pkg.sv
verilog/host_if/axil_slave.sv
verilog/host_if/csr_regs.sv
verilog/mdio/mdio_master.sv
verilog/eth_mgmt_top.sv
sim/tb_clock_gen.sv
sim/tb_eth_mgmt.sv

// File: run_sim.sh
#!/bin/sh
# Build the management block testbench with Verilator and run it.
# Exit status is 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_eth_mgmt \
    -f vlog.f \
    -o tb_eth_mgmt_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_eth_mgmt_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if echo "$sim_output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
